// ==== fetch.f ====
+incdir+include
verilog/fetch_pkg.sv
verilog/axi_rd_if.sv
verilog/inst_fetch.sv
verilog/inst_sram.sv
verilog/next_pc_unit.sv
verilog/fetch_top.sv
testbench/fetch_tb.sv

// ==== include/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// first fetch address after reset
`define RESET_PC 32'h80000000

// instruction image size in 32-bit words
`define IMEM_WORDS 32

// cycles between a handover and the next arvalid
`define AR_DELAY 6

// cycles from address acceptance to rready
`define RREADY_DELAY 4

// base read latency of the memory, low word address bits add on top
`define MEM_LAT 3

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

# the memory model reads prog.hex from the run directory
ln -sf testbench/prog.hex prog.hex || { echo "cannot link program image"; exit 1; }

verilator --binary --assert -Wno-fatal --top-module fetch_tb -f fetch.f -o fetch_tb_sim \
    || { echo "build failed"; exit 1; }

obj_dir/fetch_tb_sim | tee /dev/stderr | grep -Fqx "=== PASS ===" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== testbench/fetch_tb.sv ====
`include "fetch_macros.svh"

module fetch_tb;

    import fetch_pkg::*;

    localparam int NUM_HANDOVERS  = 60;
    localparam int TIMEOUT_CYCLES = NUM_HANDOVERS * 40;  // worst handover about 35 cycles

    logic        clk;
    logic        rst;
    logic        inst_ack;
    logic        inst_req;
    logic [31:0] pc;
    logic [31:0] inst;

    logic [31:0] image [0:`IMEM_WORDS-1];  // own copy of the program
    int          errors = 0;
    int          handovers = 0;
    int          cycles = 0;

    fetch_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .inst_req (inst_req),
        .inst_ack (inst_ack),
        .pc       (pc),
        .inst     (inst)
    );

    always #50 clk = ~clk;

    initial begin
        $readmemh("testbench/prog.hex", image);
    end

    // word the memory should return for an address, 0 outside the image
    function automatic logic [31:0] image_word(input logic [31:0] addr);
        logic [31:0] offset;
        int          idx;
        offset = addr - `RESET_PC;
        idx    = int'(offset / 32'd4);
        if (offset < 32'(4 * `IMEM_WORDS)) begin
            return image[idx];
        end
        return 32'd0;
    endfunction

    // next pc from the fetch rules, immediates rebuilt from raw bit positions
    function automatic logic [31:0] ref_next_pc(input logic [31:0] word,
                                                input logic [31:0] cur_pc);
        inst_word_u  w;
        logic [31:0] imm;
        w = word;
        if (w.j_fmt.opcode == op_jal) begin
            imm = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
            return cur_pc + imm;
        end
        if (w.b_fmt.opcode == op_branch && w.b_fmt.funct3 == f3_beq &&
            w.b_fmt.rs1 == w.b_fmt.rs2) begin
            imm = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
            return cur_pc + imm;
        end
        return cur_pc + 32'd4;  // untaken branches, jalr, everything else
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at time %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // clock and reset, then wait for enough handovers
    initial begin : main_seq
        clk = 1'b0;
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;
        while (handovers < NUM_HANDOVERS) @(posedge clk);
        $display("checked %0d handovers, %0d errors", handovers, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // core side ack, random stalls both ways
    initial begin : ack_driver
        int unsigned wait_cyc;
        inst_ack = 1'b0;
        void'($urandom(32'hf83b));
        @(negedge rst);
        forever begin
            do begin
                @(posedge clk);
                #10;
            end while (!inst_req);
            wait_cyc = $urandom % 6;  // 0..5 cycles before ack
            repeat (wait_cyc) begin
                @(posedge clk);
                #10;
            end
            inst_ack = 1'b1;
            do begin
                @(posedge clk);
                #10;
            end while (inst_req);  // hold until req drops
            wait_cyc = $urandom % 20;  // long holds outlast the refetch
            repeat (wait_cyc) begin
                @(posedge clk);
                #10;
            end
            inst_ack = 1'b0;
        end
    end

    // samples on the falling edge, well clear of both clock edge and drive point
    initial begin : compare_proc
        logic        prev_req;
        logic        prev_ack;
        logic [31:0] prev_pc;
        logic [31:0] prev_inst;
        logic [31:0] exp_pc;
        logic [31:0] exp_inst;
        prev_req  = 1'b0;
        prev_ack  = 1'b0;
        prev_pc   = 32'd0;
        prev_inst = 32'd0;
        exp_pc    = `RESET_PC;
        @(negedge rst);
        forever begin
            @(negedge clk);
            if (inst_req && !prev_req) begin
                // fresh handover
                check_value("new req before ack fell", prev_ack, 1'b0);
                exp_inst = image_word(exp_pc);
                check_value("handover pc", pc, exp_pc);
                check_value("handover inst", inst, exp_inst);
                exp_pc = ref_next_pc(exp_inst, exp_pc);
                handovers++;
            end
            if (inst_req && prev_req) begin
                check_value("pc moved while req waits", pc, prev_pc);
                check_value("inst moved while req waits", inst, prev_inst);
            end
            if (!inst_req && prev_req) begin
                check_value("req fell without ack", prev_ack, 1'b1);
            end
            prev_req  = inst_req;
            prev_ack  = inst_ack;
            prev_pc   = pc;
            prev_inst = inst;
        end
    end

    // run limit
    initial begin : watchdog
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: only %0d of %0d handovers seen after %0d cycles",
                 handovers, NUM_HANDOVERS, cycles);
        $display("checked %0d handovers, %0d errors", handovers, errors);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== testbench/prog.hex ====
// one 32-bit instruction word per line in hex
// word 0 sits at 0x80000000, each next line is pc plus 4
00100093
00200113
002081b3
0100006f
00400213
00500293
00600313
00208463
00318663
00700393
00800413
00529463
00008067
014000ef
00900493
00a00513
00b00593
00c00613
123452b7
00128313
00410863
0020e3b3
0180006f
00d00693
00e00713
00f00793
01000813
01100893
0080006f
ffdff06f
00150513
fe000ce3

// ==== verilog/axi_rd_if.sv ====
interface axi_rd_if;

    // read address channel
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;

    // read data channel
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;

    // fetch side
    modport master (
        output araddr,
        output arvalid,
        input  arready,
        input  rvalid,
        output rready,
        input  rdata
    );

    // memory side
    modport slave (
        input  araddr,
        input  arvalid,
        output arready,
        output rvalid,
        input  rready,
        output rdata
    );

endinterface

// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

    // base opcodes, low two bits always 2'b11
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_branch = 7'b1100011;

    localparam logic [2:0] f3_beq = 3'b000;

    // J-type, imm[20|10:1|11|19:12]
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // B-type, imm split around rs2/rs1/funct3
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // same word, two decodings; opcode lines up in both
    typedef union packed {
        j_fmt_t j_fmt;
        b_fmt_t b_fmt;
    } inst_word_u;

endpackage

// ==== verilog/fetch_top.sv ====
module fetch_top (
    input  logic        clk,
    input  logic        rst,
    output logic        inst_req,
    input  logic        inst_ack,
    output logic [31:0] pc,
    output logic [31:0] inst
);

    logic        jump_en;
    logic [31:0] jump_pc;

    axi_rd_if bus_i ();  // fetch to imem

    inst_fetch fetch_i (
        .clk      (clk),
        .rst      (rst),
        .jump_en  (jump_en),
        .jump_pc  (jump_pc),
        .bus      (bus_i.master),
        .inst_req (inst_req),
        .inst_ack (inst_ack),
        .pc       (pc),
        .inst     (inst)
    );

    inst_sram imem_i (
        .clk (clk),
        .rst (rst),
        .bus (bus_i.slave)
    );

    // decodes the word being handed over
    next_pc_unit npc_i (
        .inst    (inst),
        .pc      (pc),
        .jump_en (jump_en),
        .jump_pc (jump_pc)
    );

endmodule

// ==== verilog/inst_fetch.sv ====
`include "fetch_macros.svh"

module inst_fetch (
    input  logic        clk,
    input  logic        rst,
    input  logic        jump_en,
    input  logic [31:0] jump_pc,
    axi_rd_if.master    bus,
    output logic        inst_req,
    input  logic        inst_ack,
    output logic [31:0] pc,
    output logic [31:0] inst
);

    logic       ar_pend;  // a new address is wanted
    logic [3:0] ar_cnt;   // gap before next arvalid
    logic       rd_busy;  // address taken, data not yet back
    logic [3:0] rr_cnt;   // rready delay
    logic       ar_fire;
    logic       r_fire;
    logic       hand_fire;

    assign ar_fire   = bus.arvalid && bus.arready;
    assign r_fire    = bus.rvalid && bus.rready;
    assign hand_fire = inst_req && inst_ack;  // core took the word

    // pc only moves at handover, so araddr is steady while arvalid
    assign bus.araddr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (hand_fire) begin
            pc <= jump_en ? jump_pc : pc + 32'd4;
        end
    end

    // address issue
    always_ff @(posedge clk) begin
        if (rst) begin
            bus.arvalid <= 1'b0;
            ar_pend     <= 1'b1;  // fetch RESET_PC right away
            ar_cnt      <= 4'd0;
        end else begin
            if (hand_fire) begin
                ar_pend <= 1'b1;
                ar_cnt  <= 4'(`AR_DELAY);
            end else if (ar_cnt != 4'd0) begin
                ar_cnt <= ar_cnt - 4'd1;
            end

            if (ar_fire) begin
                bus.arvalid <= 1'b0;
            end else if (ar_pend && ar_cnt == 4'd0 && !inst_ack) begin
                // countdown done and ack back low
                bus.arvalid <= 1'b1;
                ar_pend     <= 1'b0;
            end
        end
    end

    // read data side, rready held back after address acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_busy   <= 1'b0;
            rr_cnt    <= 4'd0;
            bus.rready <= 1'b0;
        end else begin
            if (ar_fire) begin
                rd_busy <= 1'b1;
                rr_cnt  <= 4'(`RREADY_DELAY);
            end else begin
                if (r_fire) rd_busy <= 1'b0;
                if (rr_cnt != 4'd0) rr_cnt <= rr_cnt - 4'd1;
            end

            if (r_fire) begin
                bus.rready <= 1'b0;
            end else if (rr_cnt == 4'd1) begin
                bus.rready <= rd_busy;  // last tick of the delay
            end
        end
    end

    // instruction register, loaded at the r transfer
    always_ff @(posedge clk) begin
        if (r_fire) begin
            inst <= bus.rdata;
        end
    end

    // req toward the core, four-phase
    always_ff @(posedge clk) begin
        if (rst) begin
            inst_req <= 1'b0;
        end else if (r_fire) begin
            inst_req <= 1'b1;
        end else if (hand_fire) begin
            inst_req <= 1'b0;
        end
    end

    // rready trails an accepted address by the fixed delay
    a_rready_needs_addr : assert property (
        @(posedge clk) disable iff (rst)
        $rose(bus.rready) |-> $past(ar_fire, `RREADY_DELAY + 1)
    ) else $error("rready raised without an address accepted the set delay before");

    a_req_holds : assert property (
        @(posedge clk) disable iff (rst)
        inst_req && !inst_ack |=> inst_req
    ) else $error("req dropped before ack");

    // core sees a frozen word while it stalls
    a_pc_stable : assert property (
        @(posedge clk) disable iff (rst)
        inst_req && !inst_ack |=> $stable(pc) && $stable(inst)
    ) else $error("pc or inst moved while req waits for ack");

endmodule

// ==== verilog/inst_sram.sv ====
`include "fetch_macros.svh"

module inst_sram (
    input  logic     clk,
    input  logic     rst,
    axi_rd_if.slave  bus
);

    localparam int IDX_W = $clog2(`IMEM_WORDS);

    logic [31:0]      mem [0:`IMEM_WORDS-1];
    logic [31:0]      addr_q;    // accepted address
    logic [31:0]      offset;    // byte offset into the image
    logic [IDX_W-1:0] idx;
    logic             in_range;
    logic             busy;      // one read at a time
    logic [3:0]       lat_cnt;
    logic             ar_fire;
    logic             r_fire;

    initial begin
        $readmemh("prog.hex", mem);
    end

    assign ar_fire  = bus.arvalid && bus.arready;
    assign r_fire   = bus.rvalid && bus.rready;
    assign offset   = addr_q - `RESET_PC;
    assign idx      = offset[IDX_W+1:2];
    assign in_range = offset[31:2] < `IMEM_WORDS;  // wraps below base too

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            addr_q <= bus.araddr;
        end
    end

    // handshake and latency control
    always_ff @(posedge clk) begin
        if (rst) begin
            bus.arready <= 1'b0;
            bus.rvalid  <= 1'b0;
            busy        <= 1'b0;
            lat_cnt     <= 4'd0;
        end else begin
            // one-cycle arready pulse, a cycle after arvalid shows up
            bus.arready <= bus.arvalid && !bus.arready && !busy;

            if (ar_fire) begin
                busy    <= 1'b1;
                lat_cnt <= 4'(`MEM_LAT) + {2'b00, bus.araddr[3:2]};  // per-word latency
            end else if (lat_cnt != 4'd0) begin
                lat_cnt <= lat_cnt - 4'd1;
            end

            if (r_fire) begin
                bus.rvalid <= 1'b0;
                busy       <= 1'b0;
            end else if (lat_cnt == 4'd1) begin
                bus.rvalid <= 1'b1;
            end
        end
    end

    // data word, set up together with rvalid
    always_ff @(posedge clk) begin
        if (lat_cnt == 4'd1) begin
            bus.rdata <= in_range ? mem[idx] : 32'd0;  // outside image reads 0
        end
    end

    a_rvalid_holds : assert property (
        @(posedge clk) disable iff (rst)
        bus.rvalid && !bus.rready |=> bus.rvalid && $stable(bus.rdata)
    ) else $error("rvalid dropped or rdata changed before transfer");

endmodule

// ==== verilog/next_pc_unit.sv ====
module next_pc_unit (
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    output logic        jump_en,
    output logic [31:0] jump_pc
);

    import fetch_pkg::*;

    inst_word_u  iw;
    logic [31:0] j_imm;
    logic [31:0] b_imm;
    logic        is_jal;
    logic        is_beq_eq;

    assign iw = inst;

    // J immediate, bit 0 always zero
    assign j_imm = {{11{iw.j_fmt.imm20}},
                    iw.j_fmt.imm20,
                    iw.j_fmt.imm19_12,
                    iw.j_fmt.imm11,
                    iw.j_fmt.imm10_1,
                    1'b0};

    // B immediate
    assign b_imm = {{19{iw.b_fmt.imm12}},
                    iw.b_fmt.imm12,
                    iw.b_fmt.imm11,
                    iw.b_fmt.imm10_5,
                    iw.b_fmt.imm4_1,
                    1'b0};

    assign is_jal = iw.j_fmt.opcode == op_jal;

    // no regfile here, equal register numbers means equal values
    assign is_beq_eq = (iw.b_fmt.opcode == op_branch) &&
                       (iw.b_fmt.funct3 == f3_beq) &&
                       (iw.b_fmt.rs1 == iw.b_fmt.rs2);

    always_comb begin
        jump_en = 1'b0;
        jump_pc = pc + 32'd4;  // don't care when jump_en low
        if (is_jal) begin
            jump_en = 1'b1;
            jump_pc = pc + j_imm;
        end else if (is_beq_eq) begin
            jump_en = 1'b1;
            jump_pc = pc + b_imm;
        end
    end

endmodule
